/* design/cp0_defines.svh */
// CP0 register addresses, reset values and widths, included by the RTL and the testbench
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// ******************************
// widths
// ******************************
`define CP0_WIDTH           32          // data word of every cp0 register
`define CP0_ADDR_W          5           // mtc0/mfc0 rd field

// ******************************
// register addresses
// ******************************
`define CP0_REG_BADVADDR    5'd8
`define CP0_REG_COUNT       5'd9
`define CP0_REG_COMPARE     5'd11
`define CP0_REG_STATUS      5'd12
`define CP0_REG_CAUSE       5'd13
`define CP0_REG_EPC         5'd14

// ******************************
// reset values and write masks
// ******************************
// only CU0 set, cp0 usable out of reset
`define CP0_STATUS_RESET    32'h1000_0000

// IM[15:8], EXL[1], IE[0]
`define CP0_STATUS_WMASK    32'h0000_ff03

// IP[9:8] software interrupt bits only
`define CP0_CAUSE_WMASK     32'h0000_0300

`endif

/* design/cp0RegPkg.sv */
// register layouts of Status and Cause, and the two-way view of a CP0 data word
`default_nettype none

package cp0RegPkg;

    // ******************************
    // Status, register 12
    // ******************************
    typedef struct packed {
        logic [3:0]  cu;        // coprocessor usable, cu[0] is CU0
        logic [11:0] pad0;      // reads zero
        logic [7:0]  im;        // interrupt mask, one per pending bit
        logic [5:0]  pad1;      // reads zero
        logic        exl;       // exception level
        logic        ie;        // global interrupt enable
    } statusT;

    // ******************************
    // Cause, register 13
    // ******************************
    typedef struct packed {
        logic        bd;        // last exception hit a delay slot
        logic        ti;        // timer interrupt pending
        logic [13:0] pad0;      // reads zero
        logic [5:0]  ipHw;      // hardware lines, top one shared with timer
        logic [1:0]  ipSw;      // software interrupts, writable
        logic        pad1;      // reads zero
        logic [4:0]  excCode;   // cause of the last exception
        logic [1:0]  pad2;      // reads zero
    } causeT;

    // one mtc0 data word, read as Status or as Cause
    // depending on which register the write address hits
    typedef union packed {
        statusT status;
        causeT  cause;
    } cp0WordU;

endpackage

`default_nettype wire

/* design/excPkg.sv */
// exception codes and exception-flag bit positions shared by the CP0 blocks and the testbench
`default_nettype none

package excPkg;

    // ******************************
    // ExcCode values written to Cause
    // ******************************
    typedef enum logic [4:0] {
        excInt  = 5'd0,     // interrupt
        excAdEL = 5'd4,     // address error, load or fetch
        excAdES = 5'd5,     // address error, store
        excSys  = 5'd8,     // syscall
        excBp   = 5'd9,     // break
        excRi   = 5'd10,    // reserved instruction
        excOv   = 5'd12     // arithmetic overflow
    } excCodeE;

    // ******************************
    // excFlags vector layout
    // ******************************
    // msb is the highest priority
    localparam int excFlagW = 8;

    localparam int flagInt  = 7;   // pending interrupt taken
    localparam int flagAdIf = 6;   // misaligned instruction fetch
    localparam int flagRi   = 5;   // undecodable instruction
    localparam int flagSys  = 4;   // syscall
    localparam int flagBp   = 3;   // break
    localparam int flagOv   = 2;   // add/sub overflow
    localparam int flagAdES = 1;   // misaligned store
    localparam int flagAdEL = 0;   // misaligned load

endpackage

`default_nettype wire

/* design/excPrioritizer.sv */
// fixed-priority selector that turns the pipeline's exception flags into one exception code
`timescale 1ns/1ns
`default_nettype none

module excPrioritizer (
    input  wire logic [excPkg::excFlagW-1:0] excFlags_i,  // one bit per exception source
    input  wire logic                        eret_i,      // eret in the memory stage
    output logic                             excValid_o,  // some exception is taken
    output excPkg::excCodeE                  excCode_o,   // code of the winner
    output logic                             badFromPc_o, // BadVAddr takes the fetch pc
    output logic                             eretTake_o   // eret goes ahead
);
    import excPkg::*;

    // any flag at all means an exception this cycle
    assign excValid_o = |excFlags_i;

    // an exception on the same instruction kills the eret
    assign eretTake_o = eret_i & ~excValid_o;

    // ******************************
    // priority chain
    // ******************************
    always_comb begin
        excCode_o   = excInt;   // default, only meaningful with excValid_o
        badFromPc_o = 1'b0;
        if (excFlags_i[flagInt]) begin
            excCode_o = excInt;
        end else if (excFlags_i[flagAdIf]) begin
            excCode_o   = excAdEL;      // fetch errors share the load code
            badFromPc_o = 1'b1;         // faulting address is the pc itself
        end else if (excFlags_i[flagRi]) begin
            excCode_o = excRi;
        end else if (excFlags_i[flagSys]) begin
            excCode_o = excSys;
        end else if (excFlags_i[flagBp]) begin
            excCode_o = excBp;
        end else if (excFlags_i[flagOv]) begin
            excCode_o = excOv;
        end else if (excFlags_i[flagAdES]) begin
            excCode_o = excAdES;        // data address from the alu
        end else if (excFlags_i[flagAdEL]) begin
            excCode_o = excAdEL;        // data address from the alu
        end
    end

endmodule

`default_nettype wire

/* design/cp0Timer.sv */
// Count and Compare registers with the half-rate tick and the compare-match timer interrupt
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0Timer (
    input  wire logic                   clk,
    input  wire logic                   rst,         // async, active low
    input  wire logic                   wrEn_i,      // mtc0 strobe
    input  wire logic [`CP0_ADDR_W-1:0] wrAddr_i,
    input  wire logic [`CP0_WIDTH-1:0]  wrData_i,
    output logic      [`CP0_WIDTH-1:0]  count_o,
    output logic      [`CP0_WIDTH-1:0]  compare_o,
    output logic                        timerInt_o   // held until Compare is written
);

    logic tickPhase;    // high on the cycle before an increment
    logic countWr;
    logic compareWr;
    logic match;

    // local address decode
    assign countWr   = wrEn_i && (wrAddr_i == `CP0_REG_COUNT);
    assign compareWr = wrEn_i && (wrAddr_i == `CP0_REG_COMPARE);

    // a zero Compare never fires
    assign match = (compare_o != '0) && (count_o == compare_o);

    // ******************************
    // Count and tick phase
    // ******************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count_o   <= '0;
            tickPhase <= 1'b0;
        end else if (countWr) begin
            count_o   <= wrData_i;
            tickPhase <= 1'b0;              // phase restarts on a write
        end else begin
            tickPhase <= ~tickPhase;
            if (tickPhase) begin
                count_o <= count_o + 32'd1; // every second clock
            end
        end
    end

    // ******************************
    // Compare and timer interrupt
    // ******************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            compare_o  <= '0;
            timerInt_o <= 1'b0;
        end else if (compareWr) begin
            compare_o  <= wrData_i;
            timerInt_o <= 1'b0;     // write acknowledges and beats a match
        end else if (match) begin
            timerInt_o <= 1'b1;     // sticky
        end
    end

endmodule

`default_nettype wire

/* design/intArbiter.sv */
// interrupt arbiter that masks the pending bits and raises the request to take an interrupt
`timescale 1ns/1ns
`default_nettype none

module intArbiter (
    input  wire cp0RegPkg::statusT status_i,  // registered Status
    input  wire cp0RegPkg::causeT  cause_i,   // registered Cause
    output logic                   intReq_o   // pipeline should take an interrupt
);

    logic [7:0] pending;    // ip7..ip0
    logic [7:0] unmasked;   // pending bits that im lets through
    logic       enabled;    // interrupts globally allowed

    // hardware bits on top, software bits below, same order as im
    assign pending = {cause_i.ipHw, cause_i.ipSw};

    assign unmasked = pending & status_i.im;

    // ******************************
    // global gate
    // ******************************
    // ie on and not already inside a handler
    assign enabled = status_i.ie & ~status_i.exl;

    // any unmasked bit that gets through the gate
    assign intReq_o = enabled & (|unmasked);

endmodule

`default_nettype wire

/* design/cp0Regs.sv */
// Status, Cause, EPC and BadVAddr with exception entry, ERET and the mfc0 read multiplexer
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0Regs (
    input  wire logic                   clk,
    input  wire logic                   rst,            // async, active low
    // mtc0 / mfc0
    input  wire logic                   wrEn_i,
    input  wire logic [`CP0_ADDR_W-1:0] wrAddr_i,
    input  wire logic [`CP0_WIDTH-1:0]  wrData_i,
    input  wire logic [`CP0_ADDR_W-1:0] rdAddr_i,
    output logic      [`CP0_WIDTH-1:0]  rdData_o,
    // interrupt sources
    input  wire logic [5:0]             hwInt_i,        // external lines
    input  wire logic                   timerInt_i,
    // timer registers, for the read mux only
    input  wire logic [`CP0_WIDTH-1:0]  count_i,
    input  wire logic [`CP0_WIDTH-1:0]  compare_i,
    // from the prioritizer
    input  wire logic                   excValid_i,
    input  wire excPkg::excCodeE        excCode_i,
    input  wire logic                   badFromPc_i,
    input  wire logic                   eretTake_i,
    // faulting instruction info
    input  wire logic [`CP0_WIDTH-1:0]  pcPlus4_i,
    input  wire logic                   inDelaySlot_i,
    input  wire logic [`CP0_WIDTH-1:0]  vAddr_i,        // load/store address
    output cp0RegPkg::statusT           status_o,
    output cp0RegPkg::causeT            cause_o
);
    import cp0RegPkg::*;
    import excPkg::*;

    cp0WordU                 wrWord;     // write data in both views
    logic [`CP0_WIDTH-1:0]   epc;
    logic [`CP0_WIDTH-1:0]   badVAddr;
    logic [`CP0_WIDTH-1:0]   excPc;      // address of the faulting instruction
    logic [`CP0_WIDTH-1:0]   epcNext;
    logic                    addrErr;    // AdEL or AdES, BadVAddr gets loaded

    assign wrWord = wrData_i;

    assign excPc   = pcPlus4_i - 32'd4;
    assign epcNext = inDelaySlot_i ? excPc - 32'd4 : excPc;    // back to the branch

    assign addrErr = (excCode_i == excAdEL) || (excCode_i == excAdES);

    // ******************************
    // register update
    // ******************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            status_o <= `CP0_STATUS_RESET;
            cause_o  <= '0;
            epc      <= '0;
            badVAddr <= '0;
        end else begin
            // lines sampled every cycle, timer folded into ip7
            cause_o.ipHw <= {hwInt_i[5] | timerInt_i, hwInt_i[4:0]};
            cause_o.ti   <= timerInt_i;

            // mtc0, only the writable fields
            if (wrEn_i) begin
                case (wrAddr_i)
                    `CP0_REG_STATUS: begin
                        status_o.im  <= wrWord.status.im;
                        status_o.exl <= wrWord.status.exl;
                        status_o.ie  <= wrWord.status.ie;
                    end
                    `CP0_REG_CAUSE: begin
                        cause_o.ipSw <= wrWord.cause.ipSw;   // sw interrupts
                    end
                    `CP0_REG_EPC: begin
                        epc <= wrData_i;
                    end
                    default: begin
                        // Count/Compare live in the timer, others read only
                    end
                endcase
            end

            // exception entry overrides a same-cycle mtc0
            if (excValid_i) begin
                if (!status_o.exl) begin
                    epc        <= epcNext;      // nested entry keeps the first epc
                    cause_o.bd <= inDelaySlot_i;
                end
                status_o.exl    <= 1'b1;
                cause_o.excCode <= excCode_i;
                if (addrErr) begin
                    badVAddr <= badFromPc_i ? excPc : vAddr_i;
                end
            end else if (eretTake_i) begin
                status_o.exl <= 1'b0;           // back to user level
            end
        end
    end

    // ******************************
    // mfc0 read mux
    // ******************************
    always_comb begin
        case (rdAddr_i)
            `CP0_REG_BADVADDR: rdData_o = badVAddr;
            `CP0_REG_COUNT:    rdData_o = count_i;
            `CP0_REG_COMPARE:  rdData_o = compare_i;
            `CP0_REG_STATUS:   rdData_o = status_o;
            `CP0_REG_CAUSE:    rdData_o = cause_o;
            `CP0_REG_EPC:      rdData_o = epc;
            default:           rdData_o = '0;   // unimplemented reads zero
        endcase
    end

endmodule

`default_nettype wire

/* design/cp0Unit.sv */
// CP0 top level, driven by the memory stage, wiring prioritizer, timer, registers and arbiter
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0Unit (
    input  wire logic                        clk,
    input  wire logic                        rst,           // async, active low
    input  wire logic                        wrEn_i,        // mtc0
    input  wire logic [`CP0_ADDR_W-1:0]      wrAddr_i,
    input  wire logic [`CP0_WIDTH-1:0]       wrData_i,
    input  wire logic [`CP0_ADDR_W-1:0]      rdAddr_i,      // mfc0
    output logic      [`CP0_WIDTH-1:0]       rdData_o,
    input  wire logic [excPkg::excFlagW-1:0] excFlags_i,
    input  wire logic                        eret_i,
    input  wire logic [`CP0_WIDTH-1:0]       pcPlus4_i,
    input  wire logic                        inDelaySlot_i,
    input  wire logic [`CP0_WIDTH-1:0]       vAddr_i,
    input  wire logic [5:0]                  hwInt_i,
    output logic                             intReq_o,      // to the pipeline
    output logic                             timerInt_o
);
    import excPkg::*;
    import cp0RegPkg::*;

    logic                  excValid;
    excCodeE               excCode;
    logic                  badFromPc;
    logic                  eretTake;
    logic [`CP0_WIDTH-1:0] count;
    logic [`CP0_WIDTH-1:0] compare;
    statusT                status;
    causeT                 cause;

    // ******************************
    // exception select
    // ******************************
    excPrioritizer uPrio (
        .excFlags_i  (excFlags_i),
        .eret_i      (eret_i),
        .excValid_o  (excValid),
        .excCode_o   (excCode),
        .badFromPc_o (badFromPc),
        .eretTake_o  (eretTake)
    );

    // Count / Compare
    cp0Timer uTimer (
        .clk        (clk),
        .rst        (rst),
        .wrEn_i     (wrEn_i),
        .wrAddr_i   (wrAddr_i),
        .wrData_i   (wrData_i),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt_o)
    );

    // ******************************
    // state registers
    // ******************************
    cp0Regs uRegs (
        .clk           (clk),
        .rst           (rst),
        .wrEn_i        (wrEn_i),
        .wrAddr_i      (wrAddr_i),
        .wrData_i      (wrData_i),
        .rdAddr_i      (rdAddr_i),
        .rdData_o      (rdData_o),
        .hwInt_i       (hwInt_i),
        .timerInt_i    (timerInt_o),
        .count_i       (count),
        .compare_i     (compare),
        .excValid_i    (excValid),
        .excCode_i     (excCode),
        .badFromPc_i   (badFromPc),
        .eretTake_i    (eretTake),
        .pcPlus4_i     (pcPlus4_i),
        .inDelaySlot_i (inDelaySlot_i),
        .vAddr_i       (vAddr_i),
        .status_o      (status),
        .cause_o       (cause)
    );

    // request back to the pipeline
    intArbiter uArb (
        .status_i (status),
        .cause_i  (cause),
        .intReq_o (intReq_o)
    );

endmodule

`default_nettype wire

/* sim/tbClockGen.sv */
// clock and reset source for the CP0 testbench, 40 ns clock with reset held low for two cycles
`timescale 1ns/1ns
`default_nettype none

module tbClockGen #(
    parameter int halfPeriod  = 20,     // ns, gives the 40 ns period
    parameter int resetCycles = 2
) (
    output logic clk_o,
    output logic rst_o      // active low
);

    initial begin
        clk_o = 1'b0;
        forever #halfPeriod clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b0;
        repeat (resetCycles) @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/cp0Tb.sv */
// CP0 unit testbench driving memory-stage inputs and checking reads, timer and interrupt request
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0Tb;

    // cycle budget per test, summed into the watchdog limit
    localparam int resetLen  = 12;
    localparam int maskLen   = 40;
    localparam int excLen    = 80;
    localparam int nestLen   = 20;
    localparam int timerLen  = 60;
    localparam int intLen    = 140;
    localparam int marginLen = 48;
    localparam int watchdogCycles =
        resetLen + maskLen + excLen + nestLen + timerLen + intLen + marginLen;

    logic                   clk;
    logic                   rst;
    logic                   wrEn;
    logic [`CP0_ADDR_W-1:0] wrAddr;
    logic [`CP0_WIDTH-1:0]  wrData;
    logic [`CP0_ADDR_W-1:0] rdAddr;
    logic [`CP0_WIDTH-1:0]  rdData;
    logic [7:0]             excFlags;
    logic                   eret;
    logic [`CP0_WIDTH-1:0]  pcPlus4;
    logic                   inDelaySlot;
    logic [`CP0_WIDTH-1:0]  vAddr;
    logic [5:0]             hwInt;
    logic                   intReq;
    logic                   timerInt;

    integer seed;
    int     sinceReset = 0;     // rising edges since reset release

    // ******************************
    // reference model
    // ******************************
    logic [7:0]  mIm;
    logic        mExl;
    logic        mIe;
    logic        mBd;
    logic        mTi;
    logic [5:0]  mIpHw;
    logic [1:0]  mIpSw;
    logic [4:0]  mCode;
    logic [31:0] mEpc;
    logic [31:0] mBad;

    tbClockGen uClk (
        .clk_o (clk),
        .rst_o (rst)
    );

    cp0Unit DUT (
        .clk           (clk),
        .rst           (rst),
        .wrEn_i        (wrEn),
        .wrAddr_i      (wrAddr),
        .wrData_i      (wrData),
        .rdAddr_i      (rdAddr),
        .rdData_o      (rdData),
        .excFlags_i    (excFlags),
        .eret_i        (eret),
        .pcPlus4_i     (pcPlus4),
        .inDelaySlot_i (inDelaySlot),
        .vAddr_i       (vAddr),
        .hwInt_i       (hwInt),
        .intReq_o      (intReq),
        .timerInt_o    (timerInt)
    );

    always @(posedge clk) begin
        if (rst) begin
            sinceReset <= sinceReset + 1;
        end
    end

    // Status word as the model sees it with CU0 always on
    function automatic logic [31:0] statusWord();
        return `CP0_STATUS_RESET | {16'd0, mIm, 6'd0, mExl, mIe};
    endfunction

    // bd 31, ti 30, ipHw 15:10, ipSw 9:8, excCode 6:2
    function automatic logic [31:0] causeWord();
        return {mBd, mTi, 14'd0, mIpHw, mIpSw, 1'b0, mCode, 2'b00};
    endfunction

    // msb is the highest flag
    function automatic logic [4:0] expectedCode(input logic [7:0] f);
        casez (f)
            8'b1???????: return 5'd0;      // Int
            8'b01??????: return 5'd4;      // fetch error reports AdEL
            8'b001?????: return 5'd10;     // RI
            8'b0001????: return 5'd8;      // Sys
            8'b00001???: return 5'd9;      // Bp
            8'b000001??: return 5'd12;     // Ov
            8'b0000001?: return 5'd5;      // AdES
            default:     return 5'd4;      // AdEL from a load
        endcase
    endfunction

    function automatic logic expectedReq();
        return mIe & ~mExl & (|({mIpHw, mIpSw} & mIm));
    endfunction

    // ******************************
    // checks
    // ******************************
    task automatic stopOnFailure();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act == exp) else begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        assert (act == exp) else begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic sampleReg(input logic [4:0] addr, output logic [31:0] data);
        @(negedge clk);
        rdAddr = addr;
        #5;                 // mux settles well before the rising edge
        data = rdData;
    endtask

    task automatic checkReg(input logic [4:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] got;
        sampleReg(addr, got);
        checkValue(name, exp, got);
    endtask

    // a Compare write clears the timer interrupt at the next edge
    assert property (@(posedge clk) disable iff (!rst)
                     (wrEn && wrAddr == `CP0_REG_COMPARE) |=> !timerInt)
        else begin
            $display("Error at %0t ns: timerInt_o expected 0, got %b after a Compare write",
                     $time, $sampled(timerInt));
            stopOnFailure();
        end

    // ******************************
    // stimulus helpers
    // ******************************
    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrData = data;
        @(negedge clk);
        wrEn = 1'b0;
        if (addr == `CP0_REG_STATUS) begin
            mIm  = data[15:8];
            mExl = data[1];
            mIe  = data[0];
        end else if (addr == `CP0_REG_CAUSE) begin
            mIpSw = data[9:8];     // only sw bits writable
        end else if (addr == `CP0_REG_EPC) begin
            mEpc = data;
        end
    endtask

    task automatic raiseExc(input logic [7:0] flags, input logic [31:0] pc4,
                            input logic ds, input logic [31:0] va);
        @(negedge clk);
        excFlags    = flags;
        pcPlus4     = pc4;
        inDelaySlot = ds;
        vAddr       = va;
        @(negedge clk);
        excFlags    = 8'd0;
        inDelaySlot = 1'b0;
        if (!mExl) begin
            mEpc = ds ? pc4 - 32'd8 : pc4 - 32'd4;   // branch address in a delay slot
            mBd  = ds;
        end
        mExl  = 1'b1;
        mCode = expectedCode(flags);
        if (flags[7:6] == 2'b01) begin
            mBad = pc4 - 32'd4;                      // fetch error reports the pc itself
        end else if (flags[7:2] == 6'd0) begin
            mBad = va;                               // load or store address
        end
    endtask

    task automatic doEret();
        @(negedge clk);
        eret = 1'b1;
        @(negedge clk);
        eret = 1'b0;
        mExl = 1'b0;
    endtask

    // hang guard
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Error at %0t ns: watchdog timeout after %0d cycles, tests did not finish",
                 $time, watchdogCycles);
        stopOnFailure();
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin
        logic [31:0] d;
        logic [31:0] tmp;
        logic [31:0] pc4;
        logic [31:0] va;
        logic [31:0] cnt;
        logic [31:0] prevCount;
        logic [31:0] cStart;
        logic [7:0]  flags;
        int          delta;
        int          waited;
        logic        rose;

        seed        = 76;
        wrEn        = 1'b0;
        wrAddr      = '0;
        wrData      = '0;
        rdAddr      = '0;
        excFlags    = 8'd0;
        eret        = 1'b0;
        pcPlus4     = '0;
        inDelaySlot = 1'b0;
        vAddr       = '0;
        hwInt       = 6'd0;
        {mIm, mExl, mIe, mBd, mTi, mIpHw, mIpSw, mCode} = '0;
        mEpc = '0;
        mBad = '0;

        @(posedge rst);

        // reset values where Count may already have ticked a little
        checkReg(`CP0_REG_BADVADDR, 32'd0, "BadVAddr");
        checkReg(`CP0_REG_COMPARE, 32'd0, "Compare");
        checkReg(`CP0_REG_STATUS, `CP0_STATUS_RESET, "Status");
        checkReg(`CP0_REG_CAUSE, 32'd0, "Cause");
        checkReg(`CP0_REG_EPC, 32'd0, "EPC");
        checkReg(5'd3, 32'd0, "unmapped read");
        sampleReg(`CP0_REG_COUNT, cnt);
        assert (cnt <= sinceReset / 2 + 1) else begin
            $display("Error at %0t ns: Count is %h, too large %0d cycles after reset",
                     $time, cnt, sinceReset);
            stopOnFailure();
        end
        checkBit("intReq_o", 1'b0, intReq);
        checkBit("timerInt_o", 1'b0, timerInt);

        // masked writes
        repeat (3) begin
            d = $random(seed);
            writeReg(`CP0_REG_STATUS, d);
            checkReg(`CP0_REG_STATUS, `CP0_STATUS_RESET | (d & `CP0_STATUS_WMASK), "Status");
            d = $random(seed);
            writeReg(`CP0_REG_CAUSE, d);
            checkReg(`CP0_REG_CAUSE, d & `CP0_CAUSE_WMASK, "Cause");
            d = $random(seed);
            writeReg(`CP0_REG_EPC, d);
            checkReg(`CP0_REG_EPC, d, "EPC");
        end
        writeReg(`CP0_REG_STATUS, 32'd0);   // exl and ie off
        writeReg(`CP0_REG_CAUSE, 32'd0);

        // one entry per flag from AdEL up to Int with random lower flags underneath
        for (int pos = 0; pos <= 7; pos++) begin
            tmp   = $random(seed);
            pc4   = $random(seed) & 32'hffff_fffc;
            va    = $random(seed);
            flags = 8'd1 << pos;
            flags = flags | (tmp[7:0] & (flags - 8'd1));
            raiseExc(flags, pc4, tmp[31], va);
            checkReg(`CP0_REG_EPC, mEpc, "EPC");
            checkReg(`CP0_REG_CAUSE, causeWord(), "Cause");
            checkReg(`CP0_REG_STATUS, statusWord(), "Status");
            checkReg(`CP0_REG_BADVADDR, mBad, "BadVAddr");
            doEret();
            checkReg(`CP0_REG_STATUS, statusWord(), "Status");
        end

        // nested entry keeps epc and bd
        pc4 = $random(seed) & 32'hffff_fffc;
        raiseExc(8'h10, pc4, 1'b1, 32'd0);          // syscall in a delay slot
        checkReg(`CP0_REG_EPC, mEpc, "EPC");
        checkReg(`CP0_REG_CAUSE, causeWord(), "Cause");
        pc4 = $random(seed) & 32'hffff_fffc;
        raiseExc(8'h04, pc4, 1'b0, 32'd0);          // overflow inside the handler
        checkReg(`CP0_REG_EPC, mEpc, "EPC");
        checkReg(`CP0_REG_CAUSE, causeWord(), "Cause");
        checkReg(`CP0_REG_STATUS, statusWord(), "Status");
        doEret();
        checkReg(`CP0_REG_STATUS, statusWord(), "Status");

        // ******************************
        // timer
        // ******************************
        tmp    = $random(seed);
        cStart = tmp & 32'h00ff_ffff;               // far from wrap
        tmp    = $random(seed);
        delta  = 6 + int'(tmp[3:0]);
        writeReg(`CP0_REG_COUNT, cStart);
        writeReg(`CP0_REG_COMPARE, cStart + delta);
        checkBit("timerInt_o", 1'b0, timerInt);
        prevCount = cStart;
        waited    = 0;
        rose      = 1'b0;
        while (!rose) begin
            sampleReg(`CP0_REG_COUNT, cnt);
            waited++;
            assert (cnt >= prevCount) else begin
                $display("Error at %0t ns: Count went down from %h to %h",
                         $time, prevCount, cnt);
                stopOnFailure();
            end
            prevCount = cnt;
            if (timerInt) begin
                rose = 1'b1;
            end else begin
                assert (waited <= 2 * delta + 3) else begin
                    $display("Error at %0t ns: timerInt_o did not rise within %0d cycles",
                             $time, 2 * delta + 3);
                    stopOnFailure();
                end
            end
        end
        mTi      = 1'b1;
        mIpHw[5] = 1'b1;                            // timer shares the top line
        checkReg(`CP0_REG_CAUSE, causeWord(), "Cause");
        writeReg(`CP0_REG_COMPARE, 32'd0);          // acknowledge with a Compare that never matches
        checkBit("timerInt_o", 1'b0, timerInt);
        mTi      = 1'b0;
        mIpHw[5] = 1'b0;
        checkReg(`CP0_REG_CAUSE, causeWord(), "Cause");

        // interrupt request against the model
        repeat (20) begin
            tmp = $random(seed);
            @(negedge clk);
            hwInt = tmp[5:0];
            mIpHw = tmp[5:0];
            d = $random(seed);
            writeReg(`CP0_REG_STATUS, d);
            d = $random(seed);
            writeReg(`CP0_REG_CAUSE, d);
            checkReg(`CP0_REG_CAUSE, causeWord(), "Cause");
            checkBit("intReq_o", expectedReq(), intReq);
        end
        hwInt = 6'd0;

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/cp0RegPkg.sv
design/excPkg.sv
design/excPrioritizer.sv
design/cp0Timer.sv
design/intArbiter.sv
design/cp0Regs.sv
design/cp0Unit.sv
sim/tbClockGen.sv
sim/cp0Tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = cp0Tb
FILELIST = tb.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
